// File: compile.f
isa_pkg.sv
ctrl_pkg.sv
reg_file.sv
decode_stage.sv
exec_alu.sv
pipe_control.sv
core_top.sv
tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int max_len = 64;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        stall;
    logic        br_taken;
    logic [31:0] br_target;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] tbl_inst [max_len];
    logic [31:0] tbl_pc [max_len];
    string       tbl_name [max_len];
    int          n_entries;

    logic [31:0] ref_regs [32];
    logic [4:0]  q_addr [$];
    logic [31:0] q_data [$];
    int          q_idx [$];

    logic        stall_s;
    logic        taken_s;
    logic [31:0] target_s;
    logic        illegal_s;
    int          errors;
    int          checks;
    int          tests;

    // model results of the word accepted at the last edge
    logic        exp_taken;
    logic [31:0] exp_target;
    logic        exp_illegal;
    logic        last_wr;
    logic [4:0]  last_rd;
    int          pend_idx;

    core_top #(.xlen(32)) dut (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .stall      (stall),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] w);
        tbl_inst[n_entries] = w;
        tbl_pc[n_entries]   = 32'(n_entries * 4);
        tbl_name[n_entries] = name;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry("lui x1", enc_u(20'($urandom), 5'd1, 7'h37));
        add_entry("addi x1", enc_i(12'($urandom), 5'd1, 3'd0, 5'd1, 7'h13));
        add_entry("lui x2", enc_u(20'($urandom), 5'd2, 7'h37));
        add_entry("addi x2", enc_i(12'($urandom), 5'd2, 3'd0, 5'd2, 7'h13));
        add_entry("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        add_entry("sub", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
        add_entry("sra", enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd5));
        add_entry("slt", enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd6));
        add_entry("sltu", enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd7));
        add_entry("xor", enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd8));
        add_entry("or", enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd8));
        add_entry("and", enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd8));
        add_entry("sll", enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd8));
        add_entry("srl", enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd8));
        add_entry("slti", enc_i(12'($urandom), 5'd1, 3'd2, 5'd9, 7'h13));
        add_entry("sltiu", enc_i(12'($urandom), 5'd1, 3'd3, 5'd9, 7'h13));
        add_entry("xori", enc_i(12'($urandom), 5'd1, 3'd4, 5'd9, 7'h13));
        add_entry("ori", enc_i(12'($urandom), 5'd1, 3'd6, 5'd9, 7'h13));
        add_entry("andi", enc_i(12'($urandom), 5'd1, 3'd7, 5'd9, 7'h13));
        add_entry("slli", enc_i({7'h00, 5'd5}, 5'd1, 3'd1, 5'd10, 7'h13));
        add_entry("srli", enc_i({7'h00, 5'd9}, 5'd1, 3'd5, 5'd10, 7'h13));
        add_entry("srai", enc_i({7'h20, 5'd7}, 5'd1, 3'd5, 5'd11, 7'h13));
        add_entry("addi x0", enc_i(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
        add_entry("auipc", enc_u(20'($urandom), 5'd13, 7'h17));
        add_entry("add x0 src", enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd12));  // x0 write in flight
        add_entry("lui", enc_u(20'($urandom), 5'd14, 7'h37));
        add_entry("beq taken", enc_b(13'd8, 5'd1, 5'd1, 3'd0));
        add_entry("squashed", enc_i(12'd1, 5'd0, 3'd0, 5'd15, 7'h13));
        add_entry("bne not taken", enc_b(13'd8, 5'd1, 5'd1, 3'd1));
        add_entry("blt", enc_b(13'd8, 5'd2, 5'd1, 3'd4));
        add_entry("addi x15", enc_i(12'd2, 5'd0, 3'd0, 5'd15, 7'h13));
        add_entry("bge", enc_b(13'd8, 5'd2, 5'd1, 3'd5));
        add_entry("addi x16", enc_i(12'd3, 5'd0, 3'd0, 5'd16, 7'h13));
        add_entry("bltu", enc_b(13'd8, 5'd2, 5'd1, 3'd6));
        add_entry("addi x16", enc_i(12'd4, 5'd0, 3'd0, 5'd16, 7'h13));
        add_entry("bgeu", enc_b(13'd8, 5'd2, 5'd1, 3'd7));
        add_entry("addi x16", enc_i(12'd5, 5'd0, 3'd0, 5'd16, 7'h13));
        add_entry("jal", enc_j(21'd8, 5'd17));
        add_entry("squashed", enc_i(12'd7, 5'd17, 3'd0, 5'd18, 7'h13));  // reads the link
        add_entry("addi x19", enc_i(12'd164, 5'd0, 3'd0, 5'd19, 7'h13));
        add_entry("jalr", enc_i(12'd9, 5'd19, 3'd0, 5'd20, 7'h67));  // bit 0 cleared
        add_entry("squashed", enc_i(12'd7, 5'd0, 3'd0, 5'd18, 7'h13));
        add_entry("skipped", enc_i(12'd8, 5'd0, 3'd0, 5'd18, 7'h13));
        add_entry("lw", enc_i(12'd0, 5'd1, 3'd2, 5'd21, 7'h03));
        add_entry("sw", {7'd0, 5'd2, 5'd1, 3'd2, 5'd0, 7'h23});
        add_entry("addi x22", enc_i(12'd1, 5'd21, 3'd0, 5'd22, 7'h13));
        add_entry("add x23", enc_r(7'h00, 5'd22, 5'd22, 3'd0, 5'd23));
    endtask

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // true when a legal RV32I word reads register r
    function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
        logic [6:0] opc;
        opc = w[6:0];
        if (r == 5'd0) begin
            return 1'b0;
        end
        if (opc == 7'h33 || opc == 7'h63) begin
            return w[19:15] == r || w[24:20] == r;
        end
        if (opc == 7'h13 || opc == 7'h67) begin
            return w[19:15] == r;
        end
        return 1'b0;
    endfunction

    task automatic run_model(input int i);
        logic [31:0] w;
        logic [31:0] p;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [2:0]  f3;
        logic        wr;
        w   = tbl_inst[i];
        p   = tbl_pc[i];
        f3  = w[14:12];
        a   = ref_regs[w[19:15]];
        b   = ref_regs[w[24:20]];
        val = '0;
        wr  = 1'b1;
        exp_taken   = 1'b0;
        exp_target  = '0;
        exp_illegal = 1'b0;
        case (w[6:0])
            7'h33: val = ref_alu(f3, w[30], a, b);
            7'h13: val = ref_alu(f3, f3 == 3'd5 && w[30], a, {{20{w[31]}}, w[31:20]});
            7'h37: val = {w[31:12], 12'd0};
            7'h17: val = p + {w[31:12], 12'd0};
            7'h6f: begin
                val        = p + 32'd4;
                exp_taken  = 1'b1;
                exp_target = p + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                val        = p + 32'd4;
                exp_taken  = 1'b1;
                exp_target = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    exp_taken = a == b;
                    3'd1:    exp_taken = a != b;
                    3'd4:    exp_taken = $signed(a) < $signed(b);
                    3'd5:    exp_taken = $signed(a) >= $signed(b);
                    3'd6:    exp_taken = a < b;
                    default: exp_taken = a >= b;
                endcase
                exp_target = p + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            default: begin
                wr          = 1'b0;
                exp_illegal = 1'b1;
            end
        endcase
        last_wr = wr && w[11:7] != 5'd0;
        last_rd = w[11:7];
        if (wr) begin
            q_addr.push_back(w[11:7]);
            q_data.push_back(val);
            q_idx.push_back(i);
            if (w[11:7] != 5'd0) begin
                ref_regs[w[11:7]] = val;
            end
            pend_idx = -1;
        end else begin
            pend_idx = i;
        end
    endtask

    always @(negedge clk) begin
        stall_s   = stall;
        taken_s   = br_taken;
        target_s  = br_target;
        illegal_s = illegal;
        if (!reset && wb_en) begin
            if (q_addr.size() == 0) begin
                $display("writeback to x%0d arrived with none expected", wb_addr);
                errors++;
            end else begin
                check("wb_addr", 32'(wb_addr), 32'(q_addr.pop_front()));
                check("wb_data", wb_data, q_data.pop_front());
                tests++;
                $display("test %0d %s: writeback checked", tests, tbl_name[q_idx.pop_front()]);
            end
        end
    end

    initial begin
        int  idx;
        logic exp_stall;
        logic was_stall;
        void'($urandom(32'h631a));
        errors    = 0;
        checks    = 0;
        tests     = 0;
        n_entries = 0;
        build_table();
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        reset      <= 1'b1;
        inst_valid <= 1'b0;
        inst       <= '0;
        pc         <= '0;
        exp_taken   = 1'b0;
        exp_target  = '0;
        exp_illegal = 1'b0;
        last_wr     = 1'b0;
        last_rd     = '0;
        pend_idx    = -1;
        was_stall   = 1'b0;
        idx         = 0;
        repeat (10) @(posedge clk);
        reset      <= 1'b0;
        inst_valid <= 1'b1;
        inst       <= tbl_inst[0];
        pc         <= tbl_pc[0];
        while (idx < n_entries) begin
            @(posedge clk);
            check("br_taken", 32'(taken_s), 32'(exp_taken));
            if (exp_taken) begin
                check("br_target", target_s, exp_target);
            end
            check("illegal", 32'(illegal_s), 32'(exp_illegal));
            if (pend_idx >= 0) begin
                tests++;
                $display("test %0d %s: redirect and illegal checked", tests, tbl_name[pend_idx]);
                pend_idx = -1;
            end
            exp_stall = last_wr && reads_reg(tbl_inst[idx], last_rd) && !was_stall && !taken_s;
            check("stall", 32'(stall_s), 32'(exp_stall));
            was_stall = stall_s;
            if (taken_s) begin
                idx         = int'(target_s >> 2);
                exp_taken   = 1'b0;
                exp_illegal = 1'b0;
                last_wr     = 1'b0;
            end else if (stall_s) begin
                exp_taken   = 1'b0;
                exp_illegal = 1'b0;
                last_wr     = 1'b0;
            end else begin
                run_model(idx);
                idx++;
            end
            if (idx < n_entries) begin
                inst <= tbl_inst[idx];
                pc   <= tbl_pc[idx];
            end else begin
                inst_valid <= 1'b0;
            end
        end
        while (q_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // table length times 4 cycles plus reset and drain
    initial begin
        #1;
        repeat (n_entries * 4 + 10 + 20) @(posedge clk);
        $display("timeout: the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import ctrl_pkg::*;
#(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] pc,
    output logic            stall,
    output logic            br_taken,
    output logic [xlen-1:0] br_target,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [xlen-1:0] wb_data,
    output logic            illegal
);

    logic            flush;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [4:0]      cur_rs1;
    logic [4:0]      cur_rs2;
    logic            cur_uses_rs1;
    logic            cur_uses_rs2;
    logic            cur_legal;
    logic            d_valid;
    alu_fun_t        alu_fun;
    logic [xlen-1:0] op1_data;
    logic [xlen-1:0] op2_data;
    logic [xlen-1:0] rs2_data_q;
    logic [xlen-1:0] d_pc;
    logic [4:0]      rd_addr;
    logic            rf_wen;
    wb_sel_t         wb_sel;
    logic [xlen-1:0] b_imm;

    reg_file #(.xlen(xlen)) u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (wb_en),
        .waddr    (wb_addr),
        .wdata    (wb_data)
    );

    decode_stage #(.xlen(xlen)) u_decode (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .stall        (stall),
        .flush        (flush),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .cur_rs1      (cur_rs1),
        .cur_rs2      (cur_rs2),
        .cur_uses_rs1 (cur_uses_rs1),
        .cur_uses_rs2 (cur_uses_rs2),
        .cur_legal    (cur_legal),
        .d_valid      (d_valid),
        .alu_fun      (alu_fun),
        .op1_data     (op1_data),
        .op2_data     (op2_data),
        .rs2_data_q   (rs2_data_q),
        .d_pc         (d_pc),
        .rd_addr      (rd_addr),
        .rf_wen       (rf_wen),
        .wb_sel       (wb_sel),
        .b_imm        (b_imm),
        .illegal      (illegal)
    );

    exec_alu #(.xlen(xlen)) u_exec (
        .clk       (clk),
        .reset     (reset),
        .d_valid   (d_valid),
        .alu_fun   (alu_fun),
        .op1_data  (op1_data),
        .op2_data  (op2_data),
        .rs2_data  (rs2_data_q),
        .d_pc      (d_pc),
        .rd_addr   (rd_addr),
        .rf_wen    (rf_wen),
        .wb_sel    (wb_sel),
        .b_imm     (b_imm),
        .br_taken  (br_taken),
        .br_target (br_target),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    pipe_control u_control (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .cur_rs1      (cur_rs1),
        .cur_rs2      (cur_rs2),
        .cur_uses_rs1 (cur_uses_rs1),
        .cur_uses_rs2 (cur_uses_rs2),
        .cur_legal    (cur_legal),
        .d_valid      (d_valid),
        .rd_addr      (rd_addr),
        .rf_wen       (rf_wen),
        .br_taken     (br_taken),
        .stall        (stall),
        .flush        (flush)
    );

endmodule

`default_nettype wire

// File: pipe_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_valid,
    input  logic [4:0] cur_rs1,
    input  logic [4:0] cur_rs2,
    input  logic       cur_uses_rs1,
    input  logic       cur_uses_rs2,
    input  logic       cur_legal,
    input  logic       d_valid,
    input  logic [4:0] rd_addr,
    input  logic       rf_wen,
    input  logic       br_taken,
    output logic       stall,
    output logic       flush
);

    logic stall_done;
    logic raw_hit;

    // producer sits in the decode register, not yet written back
    assign raw_hit = d_valid && rf_wen && rd_addr != 5'd0 &&
                     ((cur_uses_rs1 && cur_rs1 == rd_addr) ||
                      (cur_uses_rs2 && cur_rs2 == rd_addr));

    // redirect wins over the hazard
    assign stall = inst_valid && cur_legal && raw_hit && !stall_done && !br_taken;
    assign flush = br_taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_done <= 1'b0;
        end else begin
            stall_done <= stall;  // one cycle per instruction
        end
    end

endmodule

`default_nettype wire

// File: exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu
    import ctrl_pkg::*;
#(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            d_valid,
    input  alu_fun_t        alu_fun,
    input  logic [xlen-1:0] op1_data,
    input  logic [xlen-1:0] op2_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] d_pc,
    input  logic [4:0]      rd_addr,
    input  logic            rf_wen,
    input  wb_sel_t         wb_sel,
    input  logic [xlen-1:0] b_imm,
    output logic            br_taken,
    output logic [xlen-1:0] br_target,
    output logic            wb_en,
    output logic [4:0]      wb_addr,
    output logic [xlen-1:0] wb_data
);

    localparam int sh_w = $clog2(xlen);

    logic [sh_w-1:0] shamt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] link;
    logic            cond;
    logic            is_jump;

    assign shamt   = op2_data[sh_w-1:0];
    assign sum     = op1_data + op2_data;
    assign link    = d_pc + xlen'(4);
    assign is_jump = wb_sel == wb_pc;

    always_comb begin
        case (alu_fun)
            alu_sub:  alu_out = op1_data - op2_data;
            alu_and:  alu_out = op1_data & op2_data;
            alu_or:   alu_out = op1_data | op2_data;
            alu_xor:  alu_out = op1_data ^ op2_data;
            alu_sll:  alu_out = op1_data << shamt;
            alu_srl:  alu_out = op1_data >> shamt;
            alu_sra:  alu_out = $signed(op1_data) >>> shamt;
            alu_slt:  alu_out = xlen'($signed(op1_data) < $signed(op2_data));
            alu_sltu: alu_out = xlen'(op1_data < op2_data);
            alu_jalr: alu_out = {sum[xlen-1:1], 1'b0};
            default:  alu_out = sum;  // add and jal target
        endcase
    end

    // branch operands are rs1 and rs2
    always_comb begin
        case (alu_fun)
            br_beq:  cond = op1_data == rs2_data;
            br_bne:  cond = op1_data != rs2_data;
            br_blt:  cond = $signed(op1_data) < $signed(rs2_data);
            br_bge:  cond = $signed(op1_data) >= $signed(rs2_data);
            br_bltu: cond = op1_data < rs2_data;
            br_bgeu: cond = op1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign br_taken  = d_valid && (cond || is_jump);
    assign br_target = is_jump ? alu_out : d_pc + b_imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= d_valid && rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= rd_addr;
        wb_data <= is_jump ? link : alu_out;
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import isa_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] pc,
    input  logic            stall,
    input  logic            flush,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic [4:0]      cur_rs1,
    output logic [4:0]      cur_rs2,
    output logic            cur_uses_rs1,
    output logic            cur_uses_rs2,
    output logic            cur_legal,
    output logic            d_valid,
    output alu_fun_t        alu_fun,
    output logic [xlen-1:0] op1_data,
    output logic [xlen-1:0] op2_data,
    output logic [xlen-1:0] rs2_data_q,
    output logic [xlen-1:0] d_pc,
    output logic [4:0]      rd_addr,
    output logic            rf_wen,
    output wb_sel_t         wb_sel,
    output logic [xlen-1:0] b_imm,
    output logic            illegal
);

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_t;
    typedef enum logic [1:0] {op2_rs2, op2_imi, op2_imj, op2_imu} op2_sel_t;

    inst_word_t      word;
    logic [31:0]     save_inst;
    logic [xlen-1:0] save_pc;
    logic            replay;
    logic            cur_valid;
    logic [xlen-1:0] cur_pc;
    logic            alt;
    logic            load;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;
    alu_fun_t        fun;
    op1_sel_t        op1_sel;
    op2_sel_t        op2_sel;
    wb_sel_t         wb;
    logic            wen;
    logic [xlen-1:0] op1_val;
    logic [xlen-1:0] op2_val;

    function automatic alu_fun_t alu_of(input logic [2:0] f3, input logic alt_op);
        case (f3)
            f3_add:  return alt_op ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_srl:  return alt_op ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // the cycle after a stall replays the saved word
    assign word      = replay ? save_inst : inst;
    assign cur_pc    = replay ? save_pc : pc;
    assign cur_valid = replay || inst_valid;

    assign cur_rs1  = word.r_fmt.rs1;
    assign cur_rs2  = word.r_fmt.rs2;
    assign rs1_addr = cur_rs1;
    assign rs2_addr = cur_rs2;
    assign alt      = word.r_fmt.funct7 == funct7_alt;

    assign imm_i = xlen'(signed'(word.i_fmt.imm));
    assign imm_b = xlen'(signed'({word.b_fmt.imm_12, word.b_fmt.imm_11,
                                  word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0}));
    assign imm_j = xlen'(signed'({word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                                  word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0}));
    assign imm_u = xlen'(signed'({word.u_fmt.imm_31_12, 12'b0}));

    always_comb begin
        cur_legal    = 1'b0;
        cur_uses_rs1 = 1'b0;
        cur_uses_rs2 = 1'b0;
        fun          = alu_add;
        op1_sel      = op1_rs1;
        op2_sel      = op2_rs2;
        wb           = wb_none;
        wen          = 1'b0;
        case (word.r_fmt.opcode)
            op_reg: begin
                cur_legal    = word.r_fmt.funct7 == 7'd0 ||
                               (alt && (word.r_fmt.funct3 == f3_add ||
                                        word.r_fmt.funct3 == f3_srl));
                cur_uses_rs1 = 1'b1;
                cur_uses_rs2 = 1'b1;
                fun          = alu_of(word.r_fmt.funct3, alt);
                wb           = wb_alu;
                wen          = 1'b1;
            end
            op_imm: begin
                // funct7 only matters for the shifts
                case (word.r_fmt.funct3)
                    f3_sll:  cur_legal = word.r_fmt.funct7 == 7'd0;
                    f3_srl:  cur_legal = word.r_fmt.funct7 == 7'd0 || alt;
                    default: cur_legal = 1'b1;
                endcase
                cur_uses_rs1 = 1'b1;
                fun          = alu_of(word.r_fmt.funct3, alt && word.r_fmt.funct3 == f3_srl);
                op2_sel      = op2_imi;
                wb           = wb_alu;
                wen          = 1'b1;
            end
            op_lui, op_auipc: begin
                cur_legal = 1'b1;
                op1_sel   = (word.r_fmt.opcode == op_lui) ? op1_zero : op1_pc;
                op2_sel   = op2_imu;
                wb        = wb_alu;
                wen       = 1'b1;
            end
            op_jal: begin
                cur_legal = 1'b1;
                op1_sel   = op1_pc;
                op2_sel   = op2_imj;
                wb        = wb_pc;
                wen       = 1'b1;
            end
            op_jalr: begin
                cur_legal    = word.r_fmt.funct3 == f3_jalr;
                cur_uses_rs1 = 1'b1;
                fun          = alu_jalr;
                op2_sel      = op2_imi;
                wb           = wb_pc;
                wen          = 1'b1;
            end
            op_branch: begin
                cur_legal    = 1'b1;
                cur_uses_rs1 = 1'b1;
                cur_uses_rs2 = 1'b1;
                case (word.r_fmt.funct3)
                    f3_beq:  fun = br_beq;
                    f3_bne:  fun = br_bne;
                    f3_blt:  fun = br_blt;
                    f3_bge:  fun = br_bge;
                    f3_bltu: fun = br_bltu;
                    f3_bgeu: fun = br_bgeu;
                    default: cur_legal = 1'b0;  // 010 and 011 unused
                endcase
            end
            default: cur_legal = 1'b0;
        endcase
    end

    always_comb begin
        case (op1_sel)
            op1_pc:   op1_val = cur_pc;
            op1_zero: op1_val = '0;
            default:  op1_val = rs1_data;
        endcase
        case (op2_sel)
            op2_imi: op2_val = imm_i;
            op2_imj: op2_val = imm_j;
            op2_imu: op2_val = imm_u;
            default: op2_val = rs2_data;
        endcase
    end

    assign load = cur_valid && cur_legal && !stall && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
            rf_wen  <= 1'b0;
            wb_sel  <= wb_none;
            alu_fun <= alu_add;
            illegal <= 1'b0;
            replay  <= 1'b0;
        end else begin
            d_valid <= load;        // bubble unless loaded
            rf_wen  <= load && wen;
            wb_sel  <= load ? wb : wb_none;
            alu_fun <= fun;
            illegal <= cur_valid && !cur_legal && !flush;
            replay  <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!replay) begin
            save_inst <= word.raw;
            save_pc   <= cur_pc;
        end
        op1_data   <= op1_val;
        op2_data   <= op2_val;
        rs2_data_q <= rs2_data;
        d_pc       <= cur_pc;
        rd_addr    <= word.r_fmt.rd;
        b_imm      <= imm_b;
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            wen,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [32];

    // write port passes through to the readers in the same cycle
    function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wen && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // 17 codes, so one bit wider than a nibble
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_jalr,   // sum with bit 0 cleared
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } alu_fun_t;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_pc       // link value pc + 4
    } wb_sel_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add  = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // srl, sra and the immediates
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] funct7_alt = 7'b0100000;  // sub and sra

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        b_fmt_t      b_fmt;
        u_fmt_t      u_fmt;
        j_fmt_t      j_fmt;
    } inst_word_t;

endpackage

`default_nettype wire
